// File: build.f
+incdir+.
fabric_pkg.sv
fabric_select.sv
fabric_addr_decode.sv
fabric_rsp_timer.sv
fabric_arbiter_fsm.sv
fabric_hsdom.sv
fabric_target_model.sv
fabric_assertions.sv
fabric_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module fabric_tb -f build.f -o fabric_sim \
    && ./obj_dir/fabric_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module fabric_tb;

    import fabric_pkg::*;

    // About 600 cycles of traffic, with generous margin
    localparam int MAX_CYCLES = 4000;
    localparam logic [31:0] SILENT_OFF = 32'h00F0_0000;

    logic clk = 1'b0;
    logic rst_n;
    logic pause_req;
    logic pause_ack;
    logic [`FABRIC_NUM_INIT-1:0] init_req_valid, init_req_ready;
    logic [`FABRIC_NUM_INIT-1:0] init_rsp_valid, init_rsp_ready;
    axil_req_t [`FABRIC_NUM_INIT-1:0] init_req;
    axil_rsp_t [`FABRIC_NUM_INIT-1:0] init_rsp;
    logic [`FABRIC_NUM_TGT-1:0] tgt_req_valid, tgt_req_ready;
    logic [`FABRIC_NUM_TGT-1:0] tgt_rsp_valid, tgt_rsp_ready;
    axil_req_t tgt_req;
    axil_rsp_t [`FABRIC_NUM_TGT-1:0] tgt_rsp;

    integer seed = 32'h240b_d062;
    logic [31:0] rnd;
    logic [31:0] bp_rnd;
    logic bp_en;
    string test_name = "reset";
    int value_errors = 0;
    int proto_errors = 0;
    int cycles = 0;
    int sent_total = 0;
    int rsp_total = 0;
    logic [31:0] shadow [3][256];
    axil_req_t stim [2][64];
    int stim_n [2];
    logic [31:0] region_base [3];

    // Expected side of the transaction in flight
    axil_rsp_t exp_rsp;
    axil_req_t exp_req;
    tgt_idx_t exp_tgt;
    logic [31:0] exp_off;
    logic exp_issue;
    int exp_init;
    logic in_flight = 1'b0;
    logic tgt_seen;
    logic rr_check = 1'b0;
    int last_grant = -1;

    always #5 clk = ~clk;

    fabric_hsdom dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .pause_req      (pause_req),
        .pause_ack      (pause_ack),
        .init_req_valid (init_req_valid),
        .init_req_ready (init_req_ready),
        .init_req       (init_req),
        .init_rsp_valid (init_rsp_valid),
        .init_rsp_ready (init_rsp_ready),
        .init_rsp       (init_rsp),
        .tgt_req_valid  (tgt_req_valid),
        .tgt_req_ready  (tgt_req_ready),
        .tgt_req        (tgt_req),
        .tgt_rsp_valid  (tgt_rsp_valid),
        .tgt_rsp_ready  (tgt_rsp_ready),
        .tgt_rsp        (tgt_rsp)
    );

    fabric_target_model #(.LATENCY(1)) u_bank0 (
        .clk (clk), .rst_n (rst_n),
        .req_valid (tgt_req_valid[0]), .req_ready (tgt_req_ready[0]), .req (tgt_req),
        .rsp_valid (tgt_rsp_valid[0]), .rsp_ready (tgt_rsp_ready[0]), .rsp (tgt_rsp[0])
    );

    fabric_target_model #(.LATENCY(3), .SILENT_BASE(SILENT_OFF)) u_bank1 (
        .clk (clk), .rst_n (rst_n),
        .req_valid (tgt_req_valid[1]), .req_ready (tgt_req_ready[1]), .req (tgt_req),
        .rsp_valid (tgt_rsp_valid[1]), .rsp_ready (tgt_rsp_ready[1]), .rsp (tgt_rsp[1])
    );

    fabric_target_model #(.LATENCY(2)) u_bridge (
        .clk (clk), .rst_n (rst_n),
        .req_valid (tgt_req_valid[2]), .req_ready (tgt_req_ready[2]), .req (tgt_req),
        .rsp_valid (tgt_rsp_valid[2]), .rsp_ready (tgt_rsp_ready[2]), .rsp (tgt_rsp[2])
    );

    function automatic logic in_region(input logic [31:0] addr, input logic [31:0] base,
                                       input logic [31:0] last);
        return (addr - base) < (last - base);
    endfunction

    // Decode, strobe merge and silent zone applied to the shadow memories
    function automatic axil_rsp_t expected_rsp(input axil_req_t req, output tgt_idx_t tgt,
                                               output logic [31:0] off, output logic issued);
        axil_rsp_t r;
        logic [7:0] w;
        r = '{rdata: '0, resp: RESP_OKAY};
        issued = 1'b1;
        tgt = '0;
        off = '0;
        if (in_region(req.addr, `FABRIC_MEM0_BASE, `FABRIC_MEM0_END)) begin
            tgt = 2'd0;
            off = req.addr - `FABRIC_MEM0_BASE;
        end else if (in_region(req.addr, `FABRIC_MEM1_BASE, `FABRIC_MEM1_END)) begin
            tgt = 2'd1;
            off = req.addr - `FABRIC_MEM1_BASE;
        end else if (in_region(req.addr, `FABRIC_LSDOM_BASE, `FABRIC_LSDOM_END)) begin
            tgt = 2'd2;
            off = req.addr - `FABRIC_LSDOM_BASE;
        end else begin
            issued = 1'b0;
            r.resp = RESP_DECERR;
        end
        w = off[9:2];
        if (issued && tgt == 2'd1 && off >= SILENT_OFF) begin
            r.resp = RESP_SLVERR;
        end else if (issued && req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    shadow[tgt][w][b*8 +: 8] = req.wdata[b*8 +: 8];
                end
            end
        end else if (issued) begin
            r.rdata = shadow[tgt][w];
        end
        return r;
    endfunction

    task automatic check_rsp(input string what, input axil_rsp_t exp, input axil_rsp_t act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_tgt_req(input string what, input axil_req_t exp, input axil_req_t act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_idx(input string what, input tgt_idx_t exp, input tgt_idx_t act);
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Error [%s] %s", test_name, msg);
        proto_errors++;
    endtask

    // Compare process watching every transfer on the DUT ports
    always @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `FABRIC_NUM_INIT; i++) begin
                if (init_rsp_valid[i] && init_rsp_ready[i]) begin
                    if (!in_flight || i != exp_init) begin
                        report_failure("response went to an initiator with nothing pending");
                    end else begin
                        if (exp_issue && !tgt_seen) begin
                            report_failure("response without a target request");
                        end
                        check_rsp("init_rsp", exp_rsp, init_rsp[i]);
                    end
                    in_flight = 1'b0;
                    rsp_total++;
                end
            end
            for (int t = 0; t < `FABRIC_NUM_TGT; t++) begin
                if (tgt_req_valid[t] && tgt_req_ready[t]) begin
                    if (!in_flight || !exp_issue || tgt_seen) begin
                        report_failure("unexpected target request");
                    end else begin
                        check_idx("target index", exp_tgt, tgt_idx_t'(t));
                        check_tgt_req("tgt_req", exp_req, tgt_req);
                    end
                    tgt_seen = 1'b1;
                end
            end
            if (pause_ack && tgt_req_valid != '0) begin
                report_failure("target request raised while paused");
            end
            for (int i = 0; i < `FABRIC_NUM_INIT; i++) begin
                if (init_req_valid[i] && init_req_ready[i]) begin
                    if (in_flight) begin
                        report_failure("request accepted with another in flight");
                    end
                    if (rr_check && init_req_valid[1-i] && last_grant == i) begin
                        report_failure("grants did not alternate under contention");
                    end
                    last_grant = i;
                    exp_rsp = expected_rsp(init_req[i], exp_tgt, exp_off, exp_issue);
                    exp_req = '{addr: exp_off, write: init_req[i].write,
                                wdata: init_req[i].wdata, wstrb: init_req[i].wstrb};
                    exp_init = i;
                    in_flight = 1'b1;
                    tgt_seen = 1'b0;
                end
            end
        end
    end

    // Random response back-pressure, drawn only while enabled
    always @(posedge clk) begin
        if (bp_en) begin
            bp_rnd = $random(seed);
            init_rsp_ready <= bp_rnd[1:0];
        end else begin
            init_rsp_ready <= 2'b11;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic axil_req_t random_req(input logic [31:0] addr, input logic write);
        logic [31:0] data;
        logic [31:0] strb;
        data = $random(seed);
        strb = $random(seed);
        return '{addr: addr, write: write, wdata: data, wstrb: strb[3:0]};
    endfunction

    function automatic logic [31:0] random_addr();
        logic [31:0] r;
        int k;
        r = $random(seed);
        k = int'(r[7:0]) % 3;
        r = $random(seed);
        return region_base[k] + (r & 32'h0007_FFFC);
    endfunction

    task automatic issue_reqs(input int i);
        @(posedge clk);
        for (int k = 0; k < stim_n[i]; k++) begin
            // Next request rises on the edge that completes the previous response
            init_req_valid[i] <= 1'b1;
            init_req[i] <= stim[i][k];
            do @(posedge clk); while (!init_req_ready[i]);
            init_req_valid[i] <= 1'b0;
            sent_total++;
            do @(posedge clk); while (!(init_rsp_valid[i] && init_rsp_ready[i]));
        end
    endtask

    task automatic run_streams();
        fork
            issue_reqs(0);
            issue_reqs(1);
        join
    endtask

    task automatic check_reset_outputs();
        if (init_req_ready !== '0 || init_rsp_valid !== '0 || tgt_req_valid !== '0 ||
            tgt_rsp_ready !== '0 || pause_ack !== 1'b0) begin
            report_failure("outputs not low around reset");
        end
    endtask

    task automatic pause_sequence();
        repeat (4) @(posedge clk);
        pause_req <= 1'b1;
        do @(posedge clk); while (!pause_ack);
        repeat (12) @(posedge clk);
        pause_req <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        if (pause_ack) begin
            report_failure("pause_ack still high after release");
        end
    endtask

    initial begin
        rst_n = 1'b0;
        pause_req = 1'b0;
        bp_en = 1'b0;
        init_req_valid = '0;
        init_req = '0;
        init_rsp_ready = '0;
        region_base = '{`FABRIC_MEM0_BASE, `FABRIC_MEM1_BASE, `FABRIC_LSDOM_BASE};
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < 256; w++) begin
                shadow[t][w] = '0;
            end
        end

        repeat (3) begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_outputs();

        test_name = "routing";
        for (int i = 0; i < 2; i++) begin
            for (int k = 0; k < 12; k++) begin
                rnd = random_addr();
                stim[i][k] = random_req(rnd, 1'b1);
                stim[i][k + 12] = random_req(rnd, 1'b0);
            end
            stim_n[i] = 24;
        end
        run_streams();

        test_name = "unmapped";
        stim[0][0] = random_req(32'h0008_0000, 1'b0);
        stim[0][1] = random_req(32'h0300_0000, 1'b1);
        stim[0][2] = random_req(32'h8000_0000, 1'b0);
        stim[0][3] = random_req(32'h00FF_FFFC, 1'b1);
        stim[1][0] = random_req(32'hFFFF_FFFC, 1'b0);
        stim[1][1] = random_req(32'h0040_0000, 1'b1);
        stim_n[0] = 4;
        stim_n[1] = 2;
        run_streams();

        test_name = "contention";
        for (int i = 0; i < 2; i++) begin
            for (int k = 0; k < 10; k++) begin
                rnd = $random(seed);
                stim[i][k] = random_req(k == 7 ? 32'h0500_0000 : random_addr(), rnd[0]);
            end
            stim_n[i] = 10;
        end
        last_grant = -1;
        @(negedge clk);
        bp_en = 1'b1;
        rr_check = 1'b1;
        run_streams();
        @(negedge clk);
        rr_check = 1'b0;
        bp_en = 1'b0;

        test_name = "timeout";
        stim[0][0] = random_req(`FABRIC_MEM1_BASE + SILENT_OFF, 1'b0);
        stim[0][1] = random_req(`FABRIC_MEM1_BASE + SILENT_OFF + 32'h40, 1'b1);
        stim[0][2] = random_req(`FABRIC_MEM1_BASE + 32'h0000_0010, 1'b0);
        stim_n[0] = 3;
        stim_n[1] = 0;
        run_streams();

        test_name = "pause";
        for (int i = 0; i < 2; i++) begin
            for (int k = 0; k < 5; k++) begin
                rnd = $random(seed);
                stim[i][k] = random_req(random_addr(), rnd[0]);
            end
            stim_n[i] = 5;
        end
        fork
            issue_reqs(0);
            issue_reqs(1);
            pause_sequence();
        join

        test_name = "end";
        repeat (3) @(posedge clk);
        if (rsp_total != sent_total || in_flight) begin
            report_failure("response count does not match accepted requests");
        end
        $display("Errors: %0d value mismatches, %0d protocol errors in %0d transactions",
                 value_errors, proto_errors, sent_total);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fabric_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module fabric_assertions (
    input logic                                         clk,
    input logic                                         rst_n,
    input logic                                         pause_ack,
    input logic [`FABRIC_NUM_INIT-1:0]                  init_rsp_valid,
    input logic [`FABRIC_NUM_INIT-1:0]                  init_rsp_ready,
    input fabric_pkg::axil_rsp_t [`FABRIC_NUM_INIT-1:0] init_rsp,
    input logic [`FABRIC_NUM_TGT-1:0]                   tgt_req_valid,
    input logic [`FABRIC_NUM_TGT-1:0]                   tgt_req_ready,
    input fabric_pkg::axil_req_t                        tgt_req
);

    // Held target request keeps valid and payload
    tgt_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        |(tgt_req_valid & ~tgt_req_ready) |=> $stable(tgt_req_valid) && $stable(tgt_req))
        else $error("target request changed before ready");

    init_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        |(init_rsp_valid & ~init_rsp_ready) |=> $stable(init_rsp_valid) && $stable(init_rsp))
        else $error("initiator response changed before ready");

    tgt_req_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(tgt_req_valid))
        else $error("more than one target request valid");

    no_req_paused: assert property (@(posedge clk) disable iff (!rst_n)
        pause_ack |-> (tgt_req_valid == '0))
        else $error("target request while paused");

endmodule

bind fabric_hsdom fabric_assertions u_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .pause_ack      (pause_ack),
    .init_rsp_valid (init_rsp_valid),
    .init_rsp_ready (init_rsp_ready),
    .init_rsp       (init_rsp),
    .tgt_req_valid  (tgt_req_valid),
    .tgt_req_ready  (tgt_req_ready),
    .tgt_req        (tgt_req)
);

`default_nettype wire

// File: fabric_target_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module fabric_target_model #(
    parameter int                        LATENCY     = 1,
    parameter logic [`FABRIC_ADDR_W-1:0] SILENT_BASE = '1
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  req_valid,
    output logic                  req_ready,
    input  fabric_pkg::axil_req_t req,

    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output fabric_pkg::axil_rsp_t rsp
);

    import fabric_pkg::*;

    logic [`FABRIC_DATA_W-1:0] mem [256];
    logic                      busy_q;
    int                        wait_q;
    logic [7:0]                word;

    assign word      = req.addr[9:2];
    assign req_ready = !busy_q;

    // Offsets at or above SILENT_BASE are taken but never answered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            rsp_valid <= 1'b0;
            wait_q    <= 0;
            rsp       <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= '0;
            end
        end else if (!busy_q) begin
            if (req_valid && req.addr < SILENT_BASE) begin
                busy_q <= 1'b1;
                wait_q <= LATENCY - 1;
                rsp    <= '{rdata: req.write ? '0 : mem[word], resp: RESP_OKAY};
                if (req.write) begin
                    for (int b = 0; b < `FABRIC_DATA_W / 8; b++) begin
                        if (req.wstrb[b]) begin
                            mem[word][b*8 +: 8] <= req.wdata[b*8 +: 8];
                        end
                    end
                end
            end
        end else if (!rsp_valid) begin
            if (wait_q == 0) begin
                rsp_valid <= 1'b1;
            end else begin
                wait_q <= wait_q - 1;
            end
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
            busy_q    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: fabric_hsdom.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module fabric_hsdom (
    input  logic                                           clk,
    input  logic                                           rst_n,

    input  logic                                           pause_req,
    output logic                                           pause_ack,

    // Initiators: CPU and DMA
    input  logic [`FABRIC_NUM_INIT-1:0]                    init_req_valid,
    output logic [`FABRIC_NUM_INIT-1:0]                    init_req_ready,
    input  fabric_pkg::axil_req_t [`FABRIC_NUM_INIT-1:0]   init_req,
    output logic [`FABRIC_NUM_INIT-1:0]                    init_rsp_valid,
    input  logic [`FABRIC_NUM_INIT-1:0]                    init_rsp_ready,
    output fabric_pkg::axil_rsp_t [`FABRIC_NUM_INIT-1:0]   init_rsp,

    // Targets: bank 0, bank 1, low-speed bridge
    output logic [`FABRIC_NUM_TGT-1:0]                     tgt_req_valid,
    input  logic [`FABRIC_NUM_TGT-1:0]                     tgt_req_ready,
    output fabric_pkg::axil_req_t                          tgt_req,
    input  logic [`FABRIC_NUM_TGT-1:0]                     tgt_rsp_valid,
    output logic [`FABRIC_NUM_TGT-1:0]                     tgt_rsp_ready,
    input  fabric_pkg::axil_rsp_t [`FABRIC_NUM_TGT-1:0]    tgt_rsp
);

    import fabric_pkg::*;

    init_idx_t                 grant;
    logic                      req_valid_sel;
    logic                      req_ready_sel;
    axil_req_t                 req_sel;

    logic                      dec_hit;
    tgt_idx_t                  dec_idx;
    logic [`FABRIC_ADDR_W-1:0] dec_offset;

    tgt_idx_t                  tgt_sel;
    logic                      rsp_valid_sel;
    logic                      rsp_ready_sel;
    axil_rsp_t                 rsp_sel;

    logic                      timer_start;
    logic                      timer_clear;
    logic                      timer_expired;

    fabric_select #(
        .payload_t (axil_req_t),
        .NUM       (`FABRIC_NUM_INIT)
    ) u_req_sel (
        .sel         (grant),
        .in_valid    (init_req_valid),
        .in_payload  (init_req),
        .in_ready    (init_req_ready),
        .out_valid   (req_valid_sel),
        .out_payload (req_sel),
        .out_ready   (req_ready_sel)
    );

    fabric_addr_decode u_decode (
        .addr        (req_sel.addr),
        .hit         (dec_hit),
        .tgt_idx     (dec_idx),
        .offset_addr (dec_offset)
    );

    fabric_select #(
        .payload_t (axil_rsp_t),
        .NUM       (`FABRIC_NUM_TGT)
    ) u_rsp_sel (
        .sel         (tgt_sel),
        .in_valid    (tgt_rsp_valid),
        .in_payload  (tgt_rsp),
        .in_ready    (tgt_rsp_ready),
        .out_valid   (rsp_valid_sel),
        .out_payload (rsp_sel),
        .out_ready   (rsp_ready_sel)
    );

    fabric_rsp_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (timer_start),
        .clear   (timer_clear),
        .expired (timer_expired)
    );

    fabric_arbiter_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .pause_req      (pause_req),
        .pause_ack      (pause_ack),
        .req_valid_any  (|init_req_valid),
        .grant          (grant),
        .sel_req_valid  (req_valid_sel),
        .sel_req        (req_sel),
        .sel_req_ready  (req_ready_sel),
        .hit            (dec_hit),
        .tgt_idx        (dec_idx),
        .offset_addr    (dec_offset),
        .tgt_sel        (tgt_sel),
        .tgt_req_valid  (tgt_req_valid),
        .tgt_req        (tgt_req),
        .tgt_req_ready  (tgt_req_ready[tgt_sel]),
        .sel_rsp_valid  (rsp_valid_sel),
        .sel_rsp        (rsp_sel),
        .sel_rsp_ready  (rsp_ready_sel),
        .timer_start    (timer_start),
        .timer_clear    (timer_clear),
        .timer_expired  (timer_expired),
        .init_rsp_valid (init_rsp_valid),
        .init_rsp       (init_rsp),
        .init_rsp_ready (init_rsp_ready)
    );

endmodule

`default_nettype wire

// File: fabric_arbiter_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module fabric_arbiter_fsm (
    input  logic                                           clk,
    input  logic                                           rst_n,

    input  logic                                           pause_req,
    output logic                                           pause_ack,

    input  logic                                           req_valid_any,
    output fabric_pkg::init_idx_t                          grant,
    input  logic                                           sel_req_valid,
    input  fabric_pkg::axil_req_t                          sel_req,
    output logic                                           sel_req_ready,

    input  logic                                           hit,
    input  fabric_pkg::tgt_idx_t                           tgt_idx,
    input  logic [`FABRIC_ADDR_W-1:0]                      offset_addr,

    output fabric_pkg::tgt_idx_t                           tgt_sel,
    output logic [`FABRIC_NUM_TGT-1:0]                     tgt_req_valid,
    output fabric_pkg::axil_req_t                          tgt_req,
    input  logic                                           tgt_req_ready,

    input  logic                                           sel_rsp_valid,
    input  fabric_pkg::axil_rsp_t                          sel_rsp,
    output logic                                           sel_rsp_ready,

    output logic                                           timer_start,
    output logic                                           timer_clear,
    input  logic                                           timer_expired,

    output logic [`FABRIC_NUM_INIT-1:0]                    init_rsp_valid,
    output fabric_pkg::axil_rsp_t [`FABRIC_NUM_INIT-1:0]   init_rsp,
    input  logic [`FABRIC_NUM_INIT-1:0]                    init_rsp_ready
);

    import fabric_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_RESPOND,
        ST_PAUSED
    } state_e;

    state_e    state_q;
    state_e    state_d;
    init_idx_t rr_ptr_q;
    init_idx_t init_q;
    tgt_idx_t  tgt_q;
    axil_req_t req_q;
    axil_rsp_t rsp_q;
    logic      accept;
    logic      rsp_done;

    assign grant         = rr_ptr_q;
    assign accept        = (state_q == ST_IDLE) && !pause_req && sel_req_valid;
    assign sel_req_ready = accept;
    assign pause_ack     = (state_q == ST_PAUSED);

    assign tgt_sel       = tgt_q;
    assign tgt_req       = req_q;
    assign sel_rsp_ready = (state_q == ST_WAIT);

    assign timer_start = (state_q == ST_ISSUE) && tgt_req_ready;
    assign timer_clear = (state_q == ST_WAIT) && (sel_rsp_valid || timer_expired);
    assign rsp_done    = (state_q == ST_RESPOND) && init_rsp_ready[init_q];

    always_comb begin
        for (int i = 0; i < `FABRIC_NUM_TGT; i++) begin
            tgt_req_valid[i] = (state_q == ST_ISSUE) && (tgt_q == tgt_idx_t'(i));
        end
        // Payload is shared, valid goes to the owner only
        for (int i = 0; i < `FABRIC_NUM_INIT; i++) begin
            init_rsp_valid[i] = (state_q == ST_RESPOND) && (init_q == init_idx_t'(i));
            init_rsp[i]       = rsp_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (pause_req) begin
                    state_d = ST_PAUSED;
                end else if (accept) begin
                    state_d = hit ? ST_ISSUE : ST_RESPOND;
                end
            end
            ST_ISSUE:   if (tgt_req_ready) state_d = ST_WAIT;
            ST_WAIT:    if (sel_rsp_valid || timer_expired) state_d = ST_RESPOND;
            ST_RESPOND: if (rsp_done) state_d = ST_IDLE;
            ST_PAUSED:  if (!pause_req) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            rr_ptr_q <= '0;
            init_q   <= '0;
            tgt_q    <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                init_q   <= grant;
                tgt_q    <= tgt_idx;
                rr_ptr_q <= ~grant;
            end else if (req_valid_any && !sel_req_valid) begin
                // Preferred initiator idle, move to the one waiting
                rr_ptr_q <= ~rr_ptr_q;
            end else if (rsp_done && !req_valid_any) begin
                rr_ptr_q <= init_q;
            end
        end
    end

    // Request keeps the offset address toward the target
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= '{
                addr:  offset_addr,
                write: sel_req.write,
                wdata: sel_req.wdata,
                wstrb: sel_req.wstrb
            };
        end
        if (accept && !hit) begin
            rsp_q <= '{rdata: '0, resp: RESP_DECERR};
        end else if (state_q == ST_WAIT && sel_rsp_valid) begin
            rsp_q <= sel_rsp;
        end else if (state_q == ST_WAIT && timer_expired) begin
            rsp_q <= '{rdata: '0, resp: RESP_SLVERR};
        end
    end

endmodule

`default_nettype wire

// File: fabric_rsp_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module fabric_rsp_timer (
    input  logic clk,
    input  logic rst_n,

    input  logic start,
    input  logic clear,
    output logic expired
);

    localparam int CNT_W = $clog2(`FABRIC_RSP_TIMEOUT + 1);

    logic [CNT_W-1:0] count_q;
    logic             running_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_q <= 1'b0;
            count_q   <= '0;
        end else if (start) begin
            running_q <= 1'b1;
            count_q   <= '0;
        end else if (clear) begin
            running_q <= 1'b0;
        end else if (running_q && !expired) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Count holds cycles already spent, so this is the last allowed one
    assign expired = running_q && (count_q == CNT_W'(`FABRIC_RSP_TIMEOUT - 1));

endmodule

`default_nettype wire

// File: fabric_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defs.svh"

module fabric_addr_decode (
    input  logic [`FABRIC_ADDR_W-1:0] addr,

    output logic                      hit,
    output fabric_pkg::tgt_idx_t      tgt_idx,
    output logic [`FABRIC_ADDR_W-1:0] offset_addr
);

    import fabric_pkg::*;

    rule_t [`FABRIC_NUM_TGT-1:0] addr_map;

    // Memory banks
    assign addr_map[0] = '{
        idx:        tgt_idx_t'(0),
        start_addr: `FABRIC_MEM0_BASE,
        end_addr:   `FABRIC_MEM0_END
    };
    assign addr_map[1] = '{
        idx:        tgt_idx_t'(1),
        start_addr: `FABRIC_MEM1_BASE,
        end_addr:   `FABRIC_MEM1_END
    };

    // Bridge to the low-speed domain
    assign addr_map[2] = '{
        idx:        tgt_idx_t'(2),
        start_addr: `FABRIC_LSDOM_BASE,
        end_addr:   `FABRIC_LSDOM_END
    };

    // Regions never overlap, so at most one rule matches
    always_comb begin
        hit         = 1'b0;
        tgt_idx     = '0;
        offset_addr = '0;
        for (int i = 0; i < `FABRIC_NUM_TGT; i++) begin
            if (addr >= addr_map[i].start_addr && addr < addr_map[i].end_addr) begin
                hit         = 1'b1;
                tgt_idx     = addr_map[i].idx;
                offset_addr = addr - addr_map[i].start_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: fabric_select.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_select #(
    parameter type payload_t = logic,
    parameter int  NUM       = 2
) (
    input  logic [$clog2(NUM)-1:0] sel,

    input  logic [NUM-1:0]         in_valid,
    input  payload_t [NUM-1:0]     in_payload,
    output logic [NUM-1:0]         in_ready,

    output logic                   out_valid,
    output payload_t               out_payload,
    input  logic                   out_ready
);

    // Forward path from the selected channel
    always_comb begin
        out_valid   = 1'b0;
        out_payload = '0;
        for (int i = 0; i < NUM; i++) begin
            if (sel == i) begin
                out_valid   = in_valid[i];
                out_payload = in_payload[i];
            end
        end
    end

    // Ready goes back to the selected channel only
    always_comb begin
        in_ready = '0;
        for (int i = 0; i < NUM; i++) begin
            if (sel == i) begin
                in_ready[i] = out_ready;
            end
        end
    end

endmodule

`default_nettype wire

// File: fabric_pkg.sv
`default_nettype none

`include "fabric_defs.svh"

package fabric_pkg;

    // Response codes, AXI encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef logic [$clog2(`FABRIC_NUM_TGT)-1:0] tgt_idx_t;
    typedef logic [$clog2(`FABRIC_NUM_INIT)-1:0] init_idx_t;

    // Shared read/write request
    typedef struct packed {
        logic [`FABRIC_ADDR_W-1:0]   addr;
        logic                        write;
        logic [`FABRIC_DATA_W-1:0]   wdata;
        logic [`FABRIC_DATA_W/8-1:0] wstrb;
    } axil_req_t;

    typedef struct packed {
        logic [`FABRIC_DATA_W-1:0] rdata;
        resp_e                     resp;
    } axil_rsp_t;

    // One entry of the address map
    typedef struct packed {
        tgt_idx_t                  idx;
        logic [`FABRIC_ADDR_W-1:0] start_addr;
        logic [`FABRIC_ADDR_W-1:0] end_addr;
    } rule_t;

endpackage

`default_nettype wire

// File: fabric_defs.svh
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// Bus widths
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32

// Port counts
`define FABRIC_NUM_INIT 2
`define FABRIC_NUM_TGT 3

// Region bounds, end is exclusive
`define FABRIC_MEM0_BASE 32'h0100_0000
`define FABRIC_MEM0_END 32'h0200_0000
`define FABRIC_MEM1_BASE 32'h0200_0000
`define FABRIC_MEM1_END 32'h0300_0000
`define FABRIC_LSDOM_BASE 32'h0000_0000
`define FABRIC_LSDOM_END 32'h0008_0000

// Cycles in the wait state before a slave error
`define FABRIC_RSP_TIMEOUT 16

`endif
